// ==== filelist.f ====
+incdir+include
verilog/usb_bulk_pkg.sv
verilog/axis_skid.sv
verilog/bulk_in_select.sv
verilog/telemetry_fifo.sv
verilog/config_desc_rom.sv
verilog/usb_bulk_frontend.sv
sim/usb_bulk_frontend_tb.sv

// ==== sim/usb_bulk_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_bulk_cfg.svh"

module usb_bulk_frontend_tb
  import usb_bulk_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int PKT_BYTES = `TELE_PACKET_WORDS * 4;
  localparam int DEPTH = `TELE_FIFO_DEPTH;
  localparam int USER_BYTES = 24;
  localparam int TELE_WORDS = 16;
  localparam int LEVEL_WORDS = 20;
  localparam int FLOOD_WORDS = 260;
  localparam int HELD_WORDS = DEPTH + 1;  // FIFO plus the word loaded in the reader

  // cycle budget per test, ready high only one cycle in four at worst
  localparam int RESET_CYC = 20;
  localparam int DESC_CYC = 60;
  localparam int USER_CYC = USER_BYTES * 8 + 50;
  localparam int TELE_CYC = TELE_WORDS * 16 + 50;
  localparam int LEVEL_CYC = LEVEL_WORDS * 3 + 80;
  localparam int FLOOD_CYC = FLOOD_WORDS + HELD_WORDS * 16 + 50;
  localparam longint WATCHDOG_NS = 2 * CLK_PERIOD *
      (RESET_CYC + DESC_CYC + USER_CYC + TELE_CYC + LEVEL_CYC + FLOOD_CYC);

  logic clock, areset_n, usb_reset_i, high_speed_i;
  endpt_t blk_endpt_i;
  logic blk_fetch_i, blk_in_ready_i;
  desc_index_t desc_index_i;
  byte_t desc_byte_o;
  logic tele_valid_i;
  tele_word_t tele_word_i;
  logic s_axis_tvalid_i, s_axis_tlast_i, s_axis_tready_o;
  byte_t s_axis_tdata_i;
  logic m_axis_tvalid_o, m_axis_tlast_o, m_axis_tready_i;
  byte_t m_axis_tdata_o;
  logic usb_reset_o, blk_in_ready_o, has_telemetry_o, tele_overflow_o;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_base = 0;
  int out_count = 0;
  int tele_byte_pos = 0;  // byte position inside the telemetry packet
  logic ready_random = 1'b0;
  logic [8:0] exp_q[$];  // {tlast, data} in output order
  byte_t desc_exp [64];

  usb_bulk_frontend usb_bulk_frontend_inst (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  // sink ready, random or held low
  always @(posedge clock) begin
    #1;
    m_axis_tready_i = ready_random ? ($urandom_range(0, 3) != 0) : 1'b0;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // every accepted output byte against the expected queue
  always @(negedge clock) begin
    if (areset_n && m_axis_tvalid_o && m_axis_tready_i) begin
      out_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Extra output byte %h at %0t ns when none was expected", m_axis_tdata_o, $time);
      end else begin
        check_value({m_axis_tlast_o, m_axis_tdata_o}, exp_q.pop_front(), "output {last,data}");
      end
    end
  end

  stall_holds_output: assert property (
    @(posedge clock) disable iff (!areset_n || usb_reset_o)
    m_axis_tvalid_o && !m_axis_tready_i |=>
      m_axis_tvalid_o && $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o)
  ) else begin
    errors++;
    $display("Mismatch at %0t ns: output changed while stalled", $time);
  end

  full_speed_not_ready: assert property (
    @(posedge clock) disable iff (!areset_n)
    !high_speed_i |=> !blk_in_ready_o
  ) else begin
    errors++;
    $display("Mismatch at %0t ns: blk_in_ready_o high without high speed", $time);
  end

  bus_reset_seen: assert property (
    @(posedge clock) disable iff (!areset_n)
    usb_reset_i |=> usb_reset_o
  ) else begin
    errors++;
    $display("Mismatch at %0t ns: usb_reset_o low after bus reset", $time);
  end

  task automatic build_desc_table();
    logic [7:0] ep_en;
    logic [7:0] addr;
    logic [15:0] total;
    byte_t head [18];
    byte_t ep [7];
    int n;
    int pos;
    ep_en = '0;
    ep_en[0] = `EP1_BULK_IN;   // EP1 IN
    ep_en[3] = `EP2_BULK_OUT;  // EP2 OUT
    ep_en[4] = `EP3_BULK_IN;   // EP3 IN
    n = 0;
    for (int k = 0; k < 8; k++) begin
      n = n + ep_en[k];
    end
    total = 16'(18 + 7 * n);
    foreach (desc_exp[i]) begin
      desc_exp[i] = 8'h00;
    end
    head = '{8'h09, 8'h02, total[7:0], total[15:8], 8'h01, 8'h01, 8'h00, 8'hC0, 8'h32,
             8'h09, 8'h04, 8'h00, 8'h00, 8'(n), 8'h00, 8'h00, 8'h00, 8'h00};
    for (int i = 0; i < 18; i++) begin
      desc_exp[i] = head[i];
    end
    pos = 18;
    for (int k = 0; k < 8; k++) begin
      if (ep_en[k]) begin
        addr = 8'(k / 2 + 1) | ((k % 2 == 0) ? 8'h80 : 8'h00);
        ep = '{8'h07, 8'h05, addr, 8'h02,
               8'(`MAX_PACKET_SIZE % 256), 8'(`MAX_PACKET_SIZE / 256), 8'h00};
        for (int j = 0; j < 7; j++) begin
          desc_exp[pos + j] = ep[j];
        end
        pos = pos + 7;
      end
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - test_base);
    test_base = errors;
  endtask

  task automatic set_ready_random(input logic on);
    @(negedge clock);
    ready_random = on;
    @(posedge clock);
    #1;
  endtask

  // bus reset pulse, the core comes back four edges later
  task automatic pulse_core_reset();
    int n;
    usb_reset_i = 1'b1;
    @(posedge clock);
    #1;
    usb_reset_i = 1'b0;
    exp_q.delete();
    tele_byte_pos = 0;
    n = 0;
    while (usb_reset_o && n < 10) begin
      @(posedge clock);
      #1;
      n++;
    end
    if (usb_reset_o) begin
      errors++;
      $display("Core reset did not end after a bus reset at %0t ns", $time);
    end
  endtask

  task automatic send_user_byte(input byte_t data, input logic last);
    s_axis_tvalid_i = 1'b1;
    s_axis_tdata_i  = data;
    s_axis_tlast_i  = last;
    @(negedge clock);
    while (!s_axis_tready_o) @(negedge clock);
    @(posedge clock);
    #1;
    s_axis_tvalid_i = 1'b0;
  endtask

  task automatic write_tele_word(input tele_word_t w);
    tele_valid_i = 1'b1;
    tele_word_i  = w;
    @(posedge clock);
    #1;
    tele_valid_i = 1'b0;
  endtask

  // lsb first, tlast on the final byte of each packet
  task automatic expect_tele_word(input tele_word_t w);
    for (int j = 0; j < 4; j++) begin
      exp_q.push_back({1'(tele_byte_pos % PKT_BYTES == PKT_BYTES - 1), w[8*j +: 8]});
      tele_byte_pos++;
    end
  endtask

  task automatic wait_drain(input int max_cycles, input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clock);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timed out at %0t ns with %0d %s bytes still missing", $time, exp_q.size(), what);
      exp_q.delete();
    end
  endtask

  task automatic check_controls_low(input string when);
    check_value(m_axis_tvalid_o, 0, {"m_axis_tvalid_o ", when});
    check_value(s_axis_tready_o, 0, {"s_axis_tready_o ", when});
    check_value(blk_in_ready_o, 0, {"blk_in_ready_o ", when});
    check_value(has_telemetry_o, 0, {"has_telemetry_o ", when});
    check_value(tele_overflow_o, 0, {"tele_overflow_o ", when});
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns, the run did not finish in time", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    tele_word_t w;
    byte_t b;
    int first_out;
    void'($urandom(32'ha1f));
    clock = 1'b0;
    areset_n = 1'b0;
    usb_reset_i = 1'b0;
    high_speed_i = 1'b0;
    blk_endpt_i = '0;
    blk_fetch_i = 1'b0;
    blk_in_ready_i = 1'b0;
    desc_index_i = '0;
    tele_valid_i = 1'b0;
    tele_word_i = '0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i = 1'b0;
    s_axis_tdata_i = '0;
    m_axis_tready_i = 1'b0;
    build_desc_table();

    // reset timing
    repeat (2) @(posedge clock);
    #1;
    check_value(usb_reset_o, 1, "usb_reset_o during areset_n");
    check_controls_low("during areset_n");
    areset_n = 1'b1;
    for (int n = 1; n <= 4; n++) begin
      @(posedge clock);
      #1;
      check_value(usb_reset_o, n < 4, $sformatf("usb_reset_o at edge %0d", n));
    end
    check_controls_low("after reset");
    usb_reset_i = 1'b1;
    @(posedge clock);
    #1;
    usb_reset_i = 1'b0;
    check_value(usb_reset_o, 1, "usb_reset_o after bus reset");
    for (int n = 1; n <= 4; n++) begin
      @(posedge clock);
      #1;
      check_value(usb_reset_o, n < 4, $sformatf("usb_reset_o at edge %0d after bus reset", n));
    end
    end_test("reset timing");

    // descriptor table, one cycle read latency
    for (int i = 0; i < 46; i++) begin
      desc_index_i = desc_index_t'(i);
      @(posedge clock);
      #1;
      check_value(desc_byte_o, desc_exp[i], $sformatf("descriptor byte %0d", i));
    end
    end_test("descriptor table");

    // user stream on endpoint 1
    high_speed_i = 1'b1;
    blk_endpt_i = endpt_t'(`USER_ENDPOINT);
    blk_fetch_i = 1'b1;
    blk_in_ready_i = 1'b1;
    set_ready_random(1'b1);
    for (int i = 0; i < USER_BYTES; i++) begin
      b = byte_t'($urandom);
      exp_q.push_back({1'(i == USER_BYTES - 1), b});
      send_user_byte(b, i == USER_BYTES - 1);
      if ($urandom_range(0, 3) == 0) begin
        @(posedge clock);  // idle gap
        #1;
      end
    end
    wait_drain(USER_CYC, "user stream");
    blk_fetch_i = 1'b0;
    end_test("user stream");

    // two telemetry packets on endpoint 2
    pulse_core_reset();
    blk_endpt_i = endpt_t'(`TELE_ENDPOINT);
    for (int i = 0; i < TELE_WORDS; i++) begin
      w = tele_word_t'($urandom);
      expect_tele_word(w);
      write_tele_word(w);
    end
    wait_drain(TELE_CYC, "telemetry");
    end_test("telemetry packets");

    // level flags, the reader keeps one word out of the level
    set_ready_random(1'b0);
    pulse_core_reset();
    blk_endpt_i = endpt_t'(`USER_ENDPOINT);
    for (int k = 1; k <= LEVEL_WORDS; k++) begin
      if (k == 9) begin
        blk_endpt_i = endpt_t'(`TELE_ENDPOINT);
      end
      blk_in_ready_i = k[0];
      write_tele_word(tele_word_t'($urandom));
      repeat (2) begin
        @(posedge clock);
        #1;
      end
      check_value(has_telemetry_o, (k - 1) >= `TELE_NOTIFY_WORDS,
                  $sformatf("has_telemetry_o after %0d words", k));
      if (k < 9) begin
        check_value(blk_in_ready_o, k[0], $sformatf("user blk_in_ready_o at word %0d", k));
      end else begin
        check_value(blk_in_ready_o, (k - 1) >= `TELE_READY_WORDS,
                    $sformatf("telemetry blk_in_ready_o after %0d words", k));
      end
    end
    high_speed_i = 1'b0;
    repeat (3) begin
      @(posedge clock);
      #1;
      check_value(blk_in_ready_o, 0, "telemetry blk_in_ready_o at full speed");
    end
    blk_endpt_i = endpt_t'(`USER_ENDPOINT);
    blk_in_ready_i = 1'b1;
    repeat (3) begin
      @(posedge clock);
      #1;
      check_value(blk_in_ready_o, 0, "user blk_in_ready_o at full speed");
    end
    high_speed_i = 1'b1;
    pulse_core_reset();
    end_test("ready flags");

    // flood with no reads, then drain everything that was kept
    for (int i = 1; i <= FLOOD_WORDS; i++) begin
      w = tele_word_t'($urandom);
      if (i <= HELD_WORDS) begin
        expect_tele_word(w);
      end
      write_tele_word(w);
      if (i == HELD_WORDS) begin
        check_value(tele_overflow_o, 0, "tele_overflow_o while words still fit");
      end else if (i == HELD_WORDS + 1) begin
        check_value(tele_overflow_o, 1, "tele_overflow_o on first dropped word");
      end
    end
    first_out = out_count;
    blk_endpt_i = endpt_t'(`TELE_ENDPOINT);
    set_ready_random(1'b1);
    wait_drain(FLOOD_CYC, "overflow drain");
    repeat (20) @(posedge clock);  // any extra byte shows up in the monitor
    #1;
    check_value(out_count - first_out, HELD_WORDS * 4, "bytes read after overflow");
    check_value(tele_overflow_o, 1, "tele_overflow_o before core reset");
    set_ready_random(1'b0);
    pulse_core_reset();
    check_value(tele_overflow_o, 0, "tele_overflow_o after core reset");
    end_test("overflow");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/usb_bulk_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_frontend
  import usb_bulk_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  logic        usb_reset_i,
  input  logic        high_speed_i,
  input  endpt_t      blk_endpt_i,
  input  logic        blk_fetch_i,
  input  logic        blk_in_ready_i,
  input  desc_index_t desc_index_i,
  output byte_t       desc_byte_o,
  input  logic        tele_valid_i,
  input  tele_word_t  tele_word_i,
  input  logic        s_axis_tvalid_i,
  input  logic        s_axis_tlast_i,
  input  byte_t       s_axis_tdata_i,
  output logic        s_axis_tready_o,
  output logic        m_axis_tvalid_o,
  output logic        m_axis_tlast_o,
  output byte_t       m_axis_tdata_o,
  input  logic        m_axis_tready_i,
  output logic        usb_reset_o,
  output logic        blk_in_ready_o,
  output logic        has_telemetry_o,
  output logic        tele_overflow_o
);

  logic [3:0] rst_chain_q;  // bit 3 is the last stage
  logic core_reset;

  tele_level_t tele_level;
  logic tele_tvalid, tele_tlast, tele_tready;
  byte_t tele_tdata;

  logic mux_tvalid, mux_tlast, mux_tready;
  byte_t mux_tdata;
  logic [8:0] skid_tdata;

  // ones shift in after areset_n rises
  // a bus reset empties the whole chain again
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_chain_q <= '0;
    end else if (usb_reset_i) begin
      rst_chain_q <= '0;
    end else begin
      rst_chain_q <= {rst_chain_q[2:0], 1'b1};
    end
  end

  assign core_reset = ~rst_chain_q[3];
  assign usb_reset_o = core_reset;

  config_desc_rom config_desc_rom_inst (
    .clock        (clock),
    .areset_n     (areset_n),
    .desc_index_i (desc_index_i),
    .desc_byte_o  (desc_byte_o)
  );

  telemetry_fifo telemetry_fifo_inst (
    .clock      (clock),
    .areset_n   (areset_n),
    .clear_i    (core_reset),
    .wr_valid_i (tele_valid_i),
    .wr_word_i  (tele_word_i),
    .level_o    (tele_level),
    .overflow_o (tele_overflow_o),
    .m_tvalid_o (tele_tvalid),
    .m_tlast_o  (tele_tlast),
    .m_tdata_o  (tele_tdata),
    .m_tready_i (tele_tready)
  );

  bulk_in_select bulk_in_select_inst (
    .clock           (clock),
    .areset_n        (areset_n),
    .clear_i         (core_reset),
    .high_speed_i    (high_speed_i),
    .endpt_i         (blk_endpt_i),
    .fetch_i         (blk_fetch_i),
    .user_ready_i    (blk_in_ready_i),
    .tele_level_i    (tele_level),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o),
    .s_user_tvalid_i (s_axis_tvalid_i),
    .s_user_tlast_i  (s_axis_tlast_i),
    .s_user_tdata_i  (s_axis_tdata_i),
    .s_user_tready_o (s_axis_tready_o),
    .s_tele_tvalid_i (tele_tvalid),
    .s_tele_tlast_i  (tele_tlast),
    .s_tele_tdata_i  (tele_tdata),
    .s_tele_tready_o (tele_tready),
    .m_tvalid_o      (mux_tvalid),
    .m_tlast_o       (mux_tlast),
    .m_tdata_o       (mux_tdata),
    .m_tready_i      (mux_tready)
  );

  // tlast rides along as the top data bit
  axis_skid #(
    .WIDTH (9)
  ) axis_skid_inst (
    .clock      (clock),
    .areset_n   (areset_n),
    .clear_i    (core_reset),
    .s_tvalid_i (mux_tvalid),
    .s_tdata_i  ({mux_tlast, mux_tdata}),
    .s_tready_o (mux_tready),
    .m_tvalid_o (m_axis_tvalid_o),
    .m_tdata_o  (skid_tdata),
    .m_tready_i (m_axis_tready_i)
  );

  assign m_axis_tlast_o = skid_tdata[8];
  assign m_axis_tdata_o = skid_tdata[7:0];

  bus_reset_holds_core: assert property (
    @(posedge clock) disable iff (!areset_n)
    usb_reset_i |=> usb_reset_o
  ) else $error("core reset not raised after usb bus reset");

endmodule

`default_nettype wire

// ==== verilog/config_desc_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_bulk_cfg.svh"

module config_desc_rom
  import usb_bulk_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  desc_index_t desc_index_i,
  output byte_t       desc_byte_o
);

  localparam int ENTRIES = 2 ** $bits(desc_index_t);

  // one enable per endpoint direction
  // even bits are IN and odd bits OUT, starting at EP1
  localparam logic [7:0] EP_DIRS = {3'b000, 1'(`EP3_BULK_IN), 1'(`EP2_BULK_OUT),
                                    2'b00, 1'(`EP1_BULK_IN)};

  localparam int NUM_EP = `EP1_BULK_IN + `EP2_BULK_OUT + `EP3_BULK_IN;
  localparam int TOTAL_LEN = 18 + 7 * NUM_EP;
  localparam logic [15:0] MPS = `MAX_PACKET_SIZE;

  // byte 0 sits in the low bits
  localparam logic [71:0] CFG_DESC = {
    8'h32,             // 100 mA
    8'hC0,             // self-powered
    8'h00,
    8'h01,             // configuration value
    8'h01,             // one interface
    16'(TOTAL_LEN),
    8'h02,
    8'h09
  };

  localparam logic [71:0] IF_DESC = {32'h0000_0000, 8'(NUM_EP), 8'h00, 8'h00, 8'h04, 8'h09};

  function automatic logic [55:0] ep_desc(input int k);
    logic [7:0] addr;
    addr = 8'(k / 2 + 1);
    if (k % 2 == 0) begin
      addr[7] = 1'b1;  // IN direction
    end
    return {8'h00, MPS, 8'h02, addr, 8'h05, 8'h07};  // bulk, no polling interval
  endfunction

  function automatic logic [ENTRIES*8-1:0] build_table();
    logic [ENTRIES*8-1:0] t;
    int pos;
    t = '0;  // unused tail reads as 00
    t[143:0] = {IF_DESC, CFG_DESC};
    pos = 18;
    for (int k = 0; k < 8; k++) begin
      if (EP_DIRS[k] && pos + 7 <= ENTRIES) begin
        t[pos*8 +: 56] = ep_desc(k);
        pos = pos + 7;
      end
    end
    return t;
  endfunction

  localparam logic [ENTRIES*8-1:0] DESC_TABLE = build_table();

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      desc_byte_o <= '0;
    end else begin
      desc_byte_o <= DESC_TABLE[{desc_index_i, 3'b000} +: 8];
    end
  end

  total_len_fits: assert property (
    @(posedge clock) disable iff (!areset_n)
    TOTAL_LEN <= ENTRIES
  ) else $error("descriptor table longer than the index range");

endmodule

`default_nettype wire

// ==== verilog/telemetry_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_bulk_cfg.svh"

module telemetry_fifo
  import usb_bulk_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  logic        clear_i,
  input  logic        wr_valid_i,
  input  tele_word_t  wr_word_i,
  output tele_level_t level_o,
  output logic        overflow_o,
  output logic        m_tvalid_o,
  output logic        m_tlast_o,
  output byte_t       m_tdata_o,
  input  logic        m_tready_i
);

  localparam int DEPTH = `TELE_FIFO_DEPTH;  // power of two, pointers wrap freely
  localparam int PTR_W = $clog2(DEPTH);
  localparam int PKT_BYTES = `TELE_PACKET_WORDS * 4;
  localparam int CNT_W = $clog2(PKT_BYTES);

  tele_word_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  tele_level_t level_q;
  logic overflow_q;
  logic full, not_empty, push, pop;

  rd_state_t state_q;
  tele_word_t word_q;
  logic [CNT_W-1:0] byte_cnt_q;  // byte position within the packet
  logic xfer, word_done;

  assign full = level_q == tele_level_t'(DEPTH);
  assign not_empty = level_q != '0;
  assign push = wr_valid_i & ~full;  // dropped when full
  assign xfer = m_tvalid_o & m_tready_i;
  assign word_done = byte_cnt_q[1:0] == 2'd3;

  // next word is loaded as soon as the current one is gone
  always_comb begin
    unique case (state_q)
      RD_IDLE:  pop = not_empty;
      RD_BYTES: pop = xfer & word_done & not_empty;
      RD_LAST:  pop = xfer & not_empty;
      default:  pop = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_word_i;
    end
    if (pop) begin
      word_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      overflow_q <= 1'b0;
    end else if (clear_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_q + tele_level_t'(push) - tele_level_t'(pop);
      if (wr_valid_i && full) begin
        overflow_q <= 1'b1;  // sticky until core reset
      end
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q    <= RD_IDLE;
      byte_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= RD_IDLE;
      byte_cnt_q <= '0;
    end else begin
      unique case (state_q)
        RD_IDLE: begin
          if (pop) begin
            state_q <= RD_BYTES;  // packet position carries over
          end
        end
        RD_BYTES: begin
          if (xfer) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == CNT_W'(PKT_BYTES - 2)) begin
              state_q <= RD_LAST;
            end else if (word_done && !pop) begin
              state_q <= RD_IDLE;  // FIFO ran dry mid packet
            end
          end
        end
        RD_LAST: begin
          if (xfer) begin
            byte_cnt_q <= '0;
            state_q    <= pop ? RD_BYTES : RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  assign m_tvalid_o = state_q != RD_IDLE;
  assign m_tlast_o  = state_q == RD_LAST;
  assign m_tdata_o  = word_q[{byte_cnt_q[1:0], 3'b000} +: 8];  // lsb first
  assign level_o    = level_q;
  assign overflow_o = overflow_q;

  level_bounded: assert property (
    @(posedge clock) disable iff (!areset_n)
    level_q <= tele_level_t'(DEPTH)
  ) else $error("telemetry level above FIFO depth");

  stall_stable: assert property (
    @(posedge clock) disable iff (!areset_n || clear_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o)
  ) else $error("telemetry output changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/bulk_in_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "usb_bulk_cfg.svh"

module bulk_in_select
  import usb_bulk_pkg::*;
(
  input  logic        clock,
  input  logic        areset_n,
  input  logic        clear_i,
  input  logic        high_speed_i,
  input  endpt_t      endpt_i,
  input  logic        fetch_i,
  input  logic        user_ready_i,
  input  tele_level_t tele_level_i,
  output logic        blk_in_ready_o,
  output logic        has_telemetry_o,
  input  logic        s_user_tvalid_i,
  input  logic        s_user_tlast_i,
  input  byte_t       s_user_tdata_i,
  output logic        s_user_tready_o,
  input  logic        s_tele_tvalid_i,
  input  logic        s_tele_tlast_i,
  input  byte_t       s_tele_tdata_i,
  output logic        s_tele_tready_o,
  output logic        m_tvalid_o,
  output logic        m_tlast_o,
  output byte_t       m_tdata_o,
  input  logic        m_tready_i
);

  localparam endpt_t USER_EP = `USER_ENDPOINT;
  localparam endpt_t TELE_EP = `TELE_ENDPOINT;
  localparam tele_level_t NOTIFY_LEVEL = `TELE_NOTIFY_WORDS;
  localparam tele_level_t READY_LEVEL = `TELE_READY_WORDS;

  logic user_ep, tele_ep;
  logic tele_sel_q, in_ready_q;

  assign user_ep = endpt_i == USER_EP;
  assign tele_ep = endpt_i == TELE_EP;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q <= 1'b0;
      in_ready_q <= 1'b0;
    end else if (clear_i) begin
      tele_sel_q <= 1'b0;
      in_ready_q <= 1'b0;
    end else begin
      tele_sel_q <= tele_ep;
      // only a high-speed link gets bulk-IN data
      in_ready_q <= high_speed_i &
                    ((user_ep & user_ready_i) | (tele_ep & (tele_level_i >= READY_LEVEL)));
    end
  end

  assign blk_in_ready_o  = in_ready_q;
  assign has_telemetry_o = tele_level_i >= NOTIFY_LEVEL;

  // user data only flows during a fetch
  assign m_tvalid_o = tele_sel_q ? s_tele_tvalid_i : (fetch_i & s_user_tvalid_i);
  assign m_tlast_o  = tele_sel_q ? s_tele_tlast_i : s_user_tlast_i;
  assign m_tdata_o  = tele_sel_q ? s_tele_tdata_i : s_user_tdata_i;

  assign s_user_tready_o = fetch_i & ~tele_sel_q & m_tready_i;
  assign s_tele_tready_o = tele_sel_q & m_tready_i;

endmodule

`default_nettype wire

// ==== verilog/axis_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_skid #(
  parameter int WIDTH = 9
) (
  input  logic             clock,
  input  logic             areset_n,
  input  logic             clear_i,
  input  logic             s_tvalid_i,
  input  logic [WIDTH-1:0] s_tdata_i,
  output logic             s_tready_o,
  output logic             m_tvalid_o,
  output logic [WIDTH-1:0] m_tdata_o,
  input  logic             m_tready_i
);

  logic [WIDTH-1:0] main_data_q, spill_data_q;
  logic main_valid_q, spill_valid_q;
  logic ready_q;  // low while the spill entry is taken
  logic s_xfer, main_free;

  assign s_xfer = s_tvalid_i & ready_q;
  assign main_free = ~main_valid_q | m_tready_i;  // main empties on this edge

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else if (clear_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
      ready_q       <= 1'b0;
    end else begin
      if (main_free) begin
        // spill drains first, ready is low whenever it holds a byte
        main_valid_q  <= spill_valid_q | s_xfer;
        spill_valid_q <= 1'b0;
        ready_q       <= 1'b1;
      end else if (s_xfer) begin
        spill_valid_q <= 1'b1;
        ready_q       <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (main_free) begin
      main_data_q <= spill_valid_q ? spill_data_q : s_tdata_i;
    end
    if (s_xfer && !main_free) begin
      spill_data_q <= s_tdata_i;
    end
  end

  assign s_tready_o = ready_q;
  assign m_tvalid_o = main_valid_q;
  assign m_tdata_o  = main_data_q;

  out_stable_while_stalled: assert property (
    @(posedge clock) disable iff (!areset_n || clear_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o)
  ) else $error("skid output changed while stalled");

endmodule

`default_nettype wire

// ==== verilog/usb_bulk_pkg.sv ====
`default_nettype none

package usb_bulk_pkg;

  // one byte on any of the 8-bit streams
  typedef logic [7:0] byte_t;

  // usb endpoint number as given by the transaction engine
  typedef logic [3:0] endpt_t;

  // raw telemetry status word
  typedef logic [31:0] tele_word_t;

  // byte offset into the configuration descriptor
  typedef logic [5:0] desc_index_t;

  // words held in the telemetry FIFO
  // one bit wider than the pointers so that full is countable
  typedef logic [8:0] tele_level_t;

  // telemetry reader
  typedef enum logic [1:0] {
    RD_IDLE,   // nothing loaded
    RD_BYTES,  // sending the loaded word byte by byte
    RD_LAST    // final byte of the packet on the bus
  } rd_state_t;

endpackage

`default_nettype wire

// ==== include/usb_bulk_cfg.svh ====
`ifndef USB_BULK_CFG_SVH
`define USB_BULK_CFG_SVH

// endpoint numbers seen on the bulk-IN path
`define USER_ENDPOINT 1   // IN data from the user stream
`define TELE_ENDPOINT 2   // IN data from the telemetry FIFO

// endpoint direction enables
// the remaining directions are always off
`define EP1_BULK_IN  1
`define EP2_BULK_OUT 1
`define EP3_BULK_IN  1

// telemetry FIFO size in 32-bit words
`define TELE_FIFO_DEPTH 256

// words per telemetry bulk-IN packet
// each word leaves as four bytes
`define TELE_PACKET_WORDS 8

// fill level that raises has_telemetry
`define TELE_NOTIFY_WORDS 4

// fill level at which the telemetry endpoint reports ready
`define TELE_READY_WORDS 16

// wMaxPacketSize for every endpoint descriptor
// high-speed bulk limit
`define MAX_PACKET_SIZE 512

`endif
